// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_user_req_path
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || { echo "Simulation did not report a pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+hw
hw/user_req_pkg.sv
hw/meta_reg.sv
hw/sq_fifo.sv
hw/user_req_mux.sv
hw/remote_req_arb.sv
hw/user_req_path.sv
test/tb_user_req_path.sv

// ==== hw/meta_reg.sv ====
`timescale 1ns/1ps

module meta_reg #(
  parameter int data_bits = 32
) (
  input  logic                 aclk,
  input  logic                 arst_n,
  input  logic                 s_valid,
  output logic                 s_ready,
  input  logic [data_bits-1:0] s_data,
  output logic                 m_valid,
  input  logic                 m_ready,
  output logic [data_bits-1:0] m_data
);

  logic                 spill_valid;      // Skid entry occupied
  logic [data_bits-1:0] spill_data;       // Word caught during a stall
  logic                 out_free;         // Main entry can be refilled
  logic                 in_xfer;          // Input handshake
  logic                 m_valid_nxt;
  logic                 spill_valid_nxt;

  assign out_free = m_ready | ~m_valid;
  assign in_xfer  = s_valid & s_ready;

  always_comb begin
    if (out_free) begin
      m_valid_nxt     = spill_valid | in_xfer;  // Spill drains first
      spill_valid_nxt = 1'b0;
    end else begin
      m_valid_nxt     = 1'b1;                   // Held under back-pressure
      spill_valid_nxt = spill_valid | in_xfer;  // Late word parks here
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid     <= 1'b0;
      spill_valid <= 1'b0;
      s_ready     <= 1'b0;
    end else begin
      m_valid     <= m_valid_nxt;
      spill_valid <= spill_valid_nxt;
      s_ready     <= ~spill_valid_nxt;  // Open while skid is empty
    end
  end

  always_ff @(posedge aclk) begin
    if (out_free) begin
      m_data <= spill_valid ? spill_data : s_data;
    end
    if (in_xfer && !out_free) begin
      spill_data <= s_data;
    end
  end

endmodule

// ==== hw/remote_req_arb.sv ====
`timescale 1ns/1ps
`include "user_req_params.svh"

module remote_req_arb
  import user_req_pkg::*;
(
  input  logic aclk,
  input  logic arst_n,
  // Remote reads
  input  logic rd_valid,
  output logic rd_ready,
  input  req_u rd_data,
  // Remote writes
  input  logic wr_valid,
  output logic wr_ready,
  input  req_u wr_data,
  // Merged network stream
  output logic net_valid,
  input  logic net_ready,
  output req_u net_data,
  output logic net_wr
);

  logic               prio_wr;    // Write wins a tie when set
  logic               gnt_rd;
  logic               gnt_wr;
  logic               arb_valid;
  logic               arb_ready;
  req_u               arb_word;
  logic [`REQ_BITS:0] arb_data;   // Flag on top of the word
  logic [`REQ_BITS:0] out_data;

  // ==========================================================
  // Round-robin grant
  // ==========================================================
  assign gnt_wr    = wr_valid & (~rd_valid | prio_wr);
  assign gnt_rd    = rd_valid & ~gnt_wr;
  assign arb_valid = rd_valid | wr_valid;
  assign arb_word  = gnt_wr ? wr_data : rd_data;
  assign arb_data  = {gnt_wr, arb_word};
  assign rd_ready  = arb_ready & gnt_rd;
  assign wr_ready  = arb_ready & gnt_wr;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      prio_wr <= 1'b0;  // Read goes first
    end else if (arb_valid && arb_ready) begin
      prio_wr <= gnt_rd;  // Pointer moves past the winner
    end
  end

  // ==========================================================
  // Output register
  // ==========================================================
  meta_reg #(.data_bits(`REQ_BITS + 1)) u_out (
    .aclk(aclk), .arst_n(arst_n),
    .s_valid(arb_valid), .s_ready(arb_ready), .s_data(arb_data),
    .m_valid(net_valid), .m_ready(net_ready), .m_data(out_data)
  );

  assign net_wr   = out_data[`REQ_BITS];
  assign net_data = out_data[`REQ_BITS-1:0];

endmodule

// ==== hw/sq_fifo.sv ====
`timescale 1ns/1ps

module sq_fifo
  import user_req_pkg::*;
#(
  parameter int depth = 4
) (
  input  logic aclk,
  input  logic arst_n,
  input  logic in_valid,
  output logic in_ready,
  input  req_u in_data,
  output logic out_valid,
  input  logic out_ready,
  output req_u out_data
);

  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_bits = $clog2(depth + 1);

  req_u                mem [depth];      // Entries behind the head
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] mem_cnt;          // Words in mem
  logic [cnt_bits-1:0] mem_cnt_nxt;
  logic [cnt_bits:0]   held_nxt;         // Words in mem plus head
  logic                push;
  logic                pop;
  logic                head_free;
  logic                head_from_mem;
  logic                head_from_in;
  logic                mem_wr;
  logic                valid_nxt;

  function automatic logic [ptr_bits-1:0] ptr_inc(input logic [ptr_bits-1:0] ptr);
    ptr_inc = (ptr == ptr_bits'(depth - 1)) ? '0 : ptr + 1'b1;  // Wrap at depth
  endfunction

  // ==========================================================
  // Head register control
  // ==========================================================
  assign push          = in_valid & in_ready;
  assign pop           = out_valid & out_ready;
  assign head_free     = ~out_valid | pop;
  assign head_from_mem = head_free & (mem_cnt != '0);
  assign head_from_in  = head_free & (mem_cnt == '0) & push;  // Bypass when empty
  assign mem_wr        = push & ~head_from_in;
  assign valid_nxt     = head_free ? (head_from_mem | head_from_in) : 1'b1;

  always_comb begin
    mem_cnt_nxt = mem_cnt;
    if (mem_wr && !head_from_mem) begin
      mem_cnt_nxt = mem_cnt + 1'b1;
    end else if (!mem_wr && head_from_mem) begin
      mem_cnt_nxt = mem_cnt - 1'b1;
    end
  end

  assign held_nxt = {1'b0, mem_cnt_nxt} + {{cnt_bits{1'b0}}, valid_nxt};

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      mem_cnt   <= '0;
      out_valid <= 1'b0;
      in_ready  <= 1'b0;  // Opens one clock after reset
    end else begin
      if (mem_wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (head_from_mem) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      mem_cnt   <= mem_cnt_nxt;
      out_valid <= valid_nxt;
      in_ready  <= held_nxt < (cnt_bits + 1)'(depth);  // Full at depth words
    end
  end

  // ==========================================================
  // Storage
  // ==========================================================
  always_ff @(posedge aclk) begin
    if (mem_wr) begin
      mem[wr_ptr] <= in_data;
    end
    if (head_from_mem) begin
      out_data <= mem[rd_ptr];  // Oldest stored word
    end else if (head_from_in) begin
      out_data <= in_data;
    end
  end

endmodule

// ==== hw/user_req_mux.sv ====
`timescale 1ns/1ps
`include "user_req_params.svh"

module user_req_mux
  import user_req_pkg::*;
#(
  parameter int id_reg = 0
) (
  input  logic aclk,
  input  logic arst_n,
  // Submission queues
  input  logic sq_rd_valid,
  output logic sq_rd_ready,
  input  req_u sq_rd_data,
  input  logic sq_wr_valid,
  output logic sq_wr_ready,
  input  req_u sq_wr_data,
  // Local memory side
  output logic local_rd_valid,
  input  logic local_rd_ready,
  output req_u local_rd_data,
  output logic local_wr_valid,
  input  logic local_wr_ready,
  output req_u local_wr_data,
  // Network side
  output logic remote_rd_valid,
  input  logic remote_rd_ready,
  output req_u remote_rd_data,
  output logic remote_wr_valid,
  input  logic remote_wr_ready,
  output req_u remote_wr_data
);

  localparam logic [`VFID_BITS-1:0] vfid_val = `VFID_BITS'(id_reg);

  // Per-channel arrays, 0 is read and 1 is write
  logic in_valid [2];
  logic in_ready [2];
  req_u in_data  [2];
  logic lo_valid [2];
  logic lo_ready [2];
  req_u lo_data  [2];
  logic re_valid [2];
  logic re_ready [2];
  req_u re_data  [2];

  assign in_valid[0]     = sq_rd_valid;
  assign in_valid[1]     = sq_wr_valid;
  assign in_data[0]      = sq_rd_data;
  assign in_data[1]      = sq_wr_data;
  assign sq_rd_ready     = in_ready[0];
  assign sq_wr_ready     = in_ready[1];

  assign local_rd_valid  = lo_valid[0];
  assign local_wr_valid  = lo_valid[1];
  assign local_rd_data   = lo_data[0];
  assign local_wr_data   = lo_data[1];
  assign lo_ready[0]     = local_rd_ready;
  assign lo_ready[1]     = local_wr_ready;

  assign remote_rd_valid = re_valid[0];
  assign remote_wr_valid = re_valid[1];
  assign remote_rd_data  = re_data[0];
  assign remote_wr_data  = re_data[1];
  assign re_ready[0]     = remote_rd_ready;
  assign re_ready[1]     = remote_wr_ready;

  for (genvar i = 0; i < 2; i++) begin : g_ch
    req_u ovr_data;    // Request with shell fields stamped
    req_u sink_data;
    logic sink_valid;
    logic sink_ready;
    logic is_remote;
    logic loc_valid;
    logic loc_ready;
    logic rem_valid;
    logic rem_ready;

    // ==========================================================
    // Stamp control fields
    // ==========================================================
    always_comb begin
      ovr_data          = in_data[i];
      ovr_data.lcl.actv = 1'b1;      // Shell issued
      ovr_data.lcl.host = 1'b0;      // Never a host access
      ovr_data.lcl.vfid = vfid_val;  // Region owner
    end

    meta_reg #(.data_bits(`REQ_BITS)) u_sink (
      .aclk(aclk), .arst_n(arst_n),
      .s_valid(in_valid[i]), .s_ready(in_ready[i]), .s_data(ovr_data),
      .m_valid(sink_valid), .m_ready(sink_ready), .m_data(sink_data)
    );

    // ==========================================================
    // Local or remote steering
    // ==========================================================
    assign is_remote  = sink_data.lcl.remote;
    assign loc_valid  = sink_valid & ~is_remote;
    assign rem_valid  = sink_valid & is_remote;
    assign sink_ready = is_remote ? rem_ready : loc_ready;  // Ready of chosen side

    meta_reg #(.data_bits(`REQ_BITS)) u_local (
      .aclk(aclk), .arst_n(arst_n),
      .s_valid(loc_valid), .s_ready(loc_ready), .s_data(sink_data),
      .m_valid(lo_valid[i]), .m_ready(lo_ready[i]), .m_data(lo_data[i])
    );

    meta_reg #(.data_bits(`REQ_BITS)) u_remote (
      .aclk(aclk), .arst_n(arst_n),
      .s_valid(rem_valid), .s_ready(rem_ready), .s_data(sink_data),
      .m_valid(re_valid[i]), .m_ready(re_ready[i]), .m_data(re_data[i])
    );
  end

endmodule

// ==== hw/user_req_params.svh ====
`ifndef USER_REQ_PARAMS_SVH
`define USER_REQ_PARAMS_SVH

// ==========================================================
// Request word geometry
// ==========================================================
`define VADDR_BITS 48   // Local virtual address
`define LEN_BITS   28   // Transfer length in bytes
`define VFID_BITS  4    // Virtual FPGA id
`define DEST_BITS  4    // Destination stream select
`define QPN_BITS   24   // Queue pair number, remote view
`define ROFF_BITS  24   // Remote offset, QPN_BITS + ROFF_BITS == VADDR_BITS
`define REQ_BITS   88   // Whole request word

// ==========================================================
// Shell configuration
// ==========================================================
`define SQ_DEPTH   4    // Entries per submission queue
`define USER_VFID  3    // Stamped into every request

`endif

// ==== hw/user_req_path.sv ====
`timescale 1ns/1ps
`include "user_req_params.svh"

module user_req_path
  import user_req_pkg::*;
(
  input  logic aclk,
  input  logic arst_n,
  // User kernel submissions
  input  logic sq_rd_valid,
  output logic sq_rd_ready,
  input  req_u sq_rd_data,
  input  logic sq_wr_valid,
  output logic sq_wr_ready,
  input  req_u sq_wr_data,
  // Local memory side
  output logic local_rd_valid,
  input  logic local_rd_ready,
  output req_u local_rd_data,
  output logic local_wr_valid,
  input  logic local_wr_ready,
  output req_u local_wr_data,
  // Network side
  output logic net_valid,
  input  logic net_ready,
  output req_u net_data,
  output logic net_wr
);

  // Queue heads into the mux
  logic q_rd_valid;
  logic q_rd_ready;
  req_u q_rd_data;
  logic q_wr_valid;
  logic q_wr_ready;
  req_u q_wr_data;

  // Remote streams into the arbiter
  logic rem_rd_valid;
  logic rem_rd_ready;
  req_u rem_rd_data;
  logic rem_wr_valid;
  logic rem_wr_ready;
  req_u rem_wr_data;

  // ==========================================================
  // Submission queues
  // ==========================================================
  sq_fifo #(.depth(`SQ_DEPTH)) u_sq_rd (
    .aclk(aclk), .arst_n(arst_n),
    .in_valid(sq_rd_valid), .in_ready(sq_rd_ready), .in_data(sq_rd_data),
    .out_valid(q_rd_valid), .out_ready(q_rd_ready), .out_data(q_rd_data)
  );

  sq_fifo #(.depth(`SQ_DEPTH)) u_sq_wr (
    .aclk(aclk), .arst_n(arst_n),
    .in_valid(sq_wr_valid), .in_ready(sq_wr_ready), .in_data(sq_wr_data),
    .out_valid(q_wr_valid), .out_ready(q_wr_ready), .out_data(q_wr_data)
  );

  // ==========================================================
  // Stamp and steer
  // ==========================================================
  user_req_mux #(.id_reg(`USER_VFID)) u_mux (
    .aclk(aclk), .arst_n(arst_n),
    .sq_rd_valid(q_rd_valid), .sq_rd_ready(q_rd_ready), .sq_rd_data(q_rd_data),
    .sq_wr_valid(q_wr_valid), .sq_wr_ready(q_wr_ready), .sq_wr_data(q_wr_data),
    .local_rd_valid(local_rd_valid), .local_rd_ready(local_rd_ready),
    .local_rd_data(local_rd_data),
    .local_wr_valid(local_wr_valid), .local_wr_ready(local_wr_ready),
    .local_wr_data(local_wr_data),
    .remote_rd_valid(rem_rd_valid), .remote_rd_ready(rem_rd_ready),
    .remote_rd_data(rem_rd_data),
    .remote_wr_valid(rem_wr_valid), .remote_wr_ready(rem_wr_ready),
    .remote_wr_data(rem_wr_data)
  );

  // Network merge
  remote_req_arb u_arb (
    .aclk(aclk), .arst_n(arst_n),
    .rd_valid(rem_rd_valid), .rd_ready(rem_rd_ready), .rd_data(rem_rd_data),
    .wr_valid(rem_wr_valid), .wr_ready(rem_wr_ready), .wr_data(rem_wr_data),
    .net_valid(net_valid), .net_ready(net_ready), .net_data(net_data),
    .net_wr(net_wr)
  );

endmodule

// ==== hw/user_req_pkg.sv ====
`include "user_req_params.svh"

package user_req_pkg;

  // ==========================================================
  // Local memory view
  // ==========================================================
  typedef struct packed {
    logic [`VADDR_BITS-1:0] vaddr;   // Virtual address
    logic [`LEN_BITS-1:0]   len;     // Bytes to move
    logic [`VFID_BITS-1:0]  vfid;    // Owner vFPGA
    logic [`DEST_BITS-1:0]  dest;    // Target stream
    logic                   remote;  // Selects the view below
    logic                   host;    // Host side access
    logic                   actv;    // Issued by this shell
    logic                   last;    // End of transfer
  } req_local_s;

  // ==========================================================
  // Remote network view
  // ==========================================================
  // Address bits hold the queue pair and the offset into it
  typedef struct packed {
    logic [`QPN_BITS-1:0]   qpn;     // Queue pair
    logic [`ROFF_BITS-1:0]  roff;    // Offset at the peer
    logic [`LEN_BITS-1:0]   len;
    logic [`VFID_BITS-1:0]  vfid;
    logic [`DEST_BITS-1:0]  dest;
    logic                   remote;  // Always set in this view
    logic                   host;
    logic                   actv;
    logic                   last;
  } req_remote_s;

  // One word, two readings; remote bit picks the meaningful one
  typedef union packed {
    req_local_s  lcl;
    req_remote_s rmt;
  } req_u;

endpackage

// ==== test/tb_user_req_path.sv ====
`timescale 1ns/1ps
`include "user_req_params.svh"

module tb_user_req_path
  import user_req_pkg::*;
();

  localparam int max_vec     = 64;
  localparam int clk_half    = 10;  // 20 ns period
  localparam int stall_start = 12;  // First cycle of the net_ready hold-off
  localparam int stall_len   = 40;

  logic aclk = 1'b0;
  logic arst_n;
  logic sq_rd_valid;
  logic sq_rd_ready;
  req_u sq_rd_data;
  logic sq_wr_valid;
  logic sq_wr_ready;
  req_u sq_wr_data;
  logic local_rd_valid;
  logic local_rd_ready = 1'b0;
  req_u local_rd_data;
  logic local_wr_valid;
  logic local_wr_ready = 1'b0;
  req_u local_wr_data;
  logic net_valid;
  logic net_ready = 1'b0;
  req_u net_data;
  logic net_wr;

  logic [99:0] vec [max_vec];            // Group, request word, destination
  req_u        exp_q [4][$];             // 0 local_rd, 1 local_wr, 2 net read, 3 net write
  int          tot_cnt [4] = '{0, 0, 0, 0};
  int          obs_cnt [4] = '{0, 0, 0, 0};
  int          n_vec = 0;
  int          n_ph1 = 0;                // Vectors of the back-pressure phase
  int          seen_cnt = 0;             // Output transfers so far
  int          errors = 0;
  int          checks = 0;
  int          cyc = 0;
  int          seed = 32'had2e_226a;
  logic        loaded = 1'b0;
  logic        burst = 1'b0;             // Steady ready phase
  logic        input_seen = 1'b0;
  logic        have_prev = 1'b0;
  logic        prev_wr = 1'b0;
  logic        prev_both = 1'b0;         // Both net kinds left after last transfer
  logic        net_stall;

  always #clk_half aclk = ~aclk;

  user_req_path DUT (.*);

  // ==========================================================
  // Checking helpers
  // ==========================================================
  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("ERROR %s", msg);
  endtask

  function automatic string port_name(input int idx);
    case (idx)
      0:       return "local_rd";
      1:       return "local_wr";
      2:       return "net read";
      default: return "net write";
    endcase
  endfunction

  function automatic logic vec_queue(input int i);
    logic [99:0] v;
    v = vec[i];
    return v[92];  // 0 read queue, 1 write queue
  endfunction

  function automatic logic vec_phase(input int i);
    logic [99:0] v;
    v = vec[i];
    return v[96];
  endfunction

  function automatic logic vec_net(input int i);
    logic [99:0] v;
    v = vec[i];
    return v[3:0] == 4'h1;
  endfunction

  function automatic req_u vec_word(input int i);
    logic [99:0] v;
    v = vec[i];
    return v[91:4];
  endfunction

  // Shell fields the path must stamp onto every request
  function automatic req_u stamp_fields(input req_u w);
    req_u e;
    e          = w;
    e.lcl.actv = 1'b1;
    e.lcl.host = 1'b0;
    e.lcl.vfid = `VFID_BITS'(`USER_VFID);
    return e;
  endfunction

  function automatic logic queue_ready(input logic q);
    return q ? sq_wr_ready : sq_rd_ready;
  endfunction

  task automatic compare_output(input int idx, input req_u act);
    req_u e;
    if (exp_q[idx].size() == 0) begin
      note_failure({"unexpected extra request on ", port_name(idx)});
    end else begin
      e = exp_q[idx].pop_front();
      check_value($sformatf("%s #%0d", port_name(idx), obs_cnt[idx]), 128'(e), 128'(act));
    end
    obs_cnt[idx]++;
    seen_cnt++;
  endtask

  // Feeds one queue with its vectors of one phase, valid held until accepted
  task automatic drive_queue(input logic q, input logic phase);
    int i;
    for (i = 0; i < n_vec; i++) begin
      if (vec_queue(i) == q && vec_phase(i) == phase) begin
        if (q) begin
          sq_wr_valid <= 1'b1;
          sq_wr_data  <= vec_word(i);
        end else begin
          sq_rd_valid <= 1'b1;
          sq_rd_data  <= vec_word(i);
        end
        @(posedge aclk);
        while (!queue_ready(q)) begin
          @(posedge aclk);
        end
      end
    end
    if (q) begin
      sq_wr_valid <= 1'b0;
    end else begin
      sq_rd_valid <= 1'b0;
    end
  endtask

  // ==========================================================
  // Output back-pressure
  // ==========================================================
  assign net_stall = (cyc >= stall_start) && (cyc < stall_start + stall_len);

  always @(posedge aclk) begin
    cyc <= cyc + 1;
    if (!arst_n) begin
      local_rd_ready <= 1'b0;
      local_wr_ready <= 1'b0;
      net_ready      <= 1'b0;
    end else if (burst) begin
      local_rd_ready <= 1'b1;
      local_wr_ready <= 1'b1;
      net_ready      <= 1'b1;
    end else begin
      local_rd_ready <= ($random(seed) & 3) != 0;  // Low about one cycle in four
      local_wr_ready <= ($random(seed) & 3) != 0;
      net_ready      <= net_stall ? 1'b0 : (($random(seed) & 3) != 0);
    end
  end

  // ==========================================================
  // Output monitor
  // ==========================================================
  always @(posedge aclk) begin
    int idx;
    if (arst_n) begin
      if (!input_seen && (local_rd_valid || local_wr_valid || net_valid)) begin
        note_failure("an output raised valid before any input was accepted");
      end
      if ((sq_rd_valid && sq_rd_ready) || (sq_wr_valid && sq_wr_ready)) begin
        input_seen = 1'b1;
      end
      if (local_rd_valid && local_rd_ready) begin
        compare_output(0, local_rd_data);
      end
      if (local_wr_valid && local_wr_ready) begin
        compare_output(1, local_wr_data);
      end
      if (net_valid && net_ready) begin
        idx = net_wr ? 3 : 2;  // Flag picks the stream
        if (exp_q[idx].size() != 0) begin
          check_value("net qpn", 128'(exp_q[idx][0].rmt.qpn), 128'(net_data.rmt.qpn));
          check_value("net roff", 128'(exp_q[idx][0].rmt.roff), 128'(net_data.rmt.roff));
        end
        compare_output(idx, net_data);
        if (burst) begin
          if (have_prev && prev_both) begin
            check_value("net alternation", 128'(!prev_wr), 128'(net_wr));
          end
          prev_wr   = net_wr;
          prev_both = (exp_q[2].size() != 0) && (exp_q[3].size() != 0);
          have_prev = 1'b1;
        end
      end
    end
  end

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    int i;
    int idx;
    arst_n      = 1'b0;
    sq_rd_valid = 1'b0;
    sq_rd_data  = '0;
    sq_wr_valid = 1'b0;
    sq_wr_data  = '0;
    for (i = 0; i < max_vec; i++) begin
      vec[i] = '1;  // Group ff ends the list
    end
    $readmemh("test/user_req_testdata.txt", vec);
    while (n_vec < max_vec && vec[n_vec][99:92] != 8'hff) begin
      n_vec++;
    end
    if (n_vec == 0) begin
      note_failure("no vectors were read from the data file");
    end
    for (i = 0; i < n_vec; i++) begin
      idx = (vec_net(i) ? 2 : 0) + (vec_queue(i) ? 1 : 0);
      exp_q[idx].push_back(stamp_fields(vec_word(i)));
      tot_cnt[idx]++;
      if (!vec_phase(i)) begin
        n_ph1++;
      end
    end
    loaded = 1'b1;

    repeat (2) @(posedge aclk);
    check_value("outputs in reset", 128'(0),
                128'({local_rd_valid, local_wr_valid, net_valid, sq_rd_ready, sq_wr_ready}));
    arst_n <= 1'b1;
    repeat (4) @(posedge aclk);  // Idle, nothing may come out

    fork
      drive_queue(1'b0, 1'b0);
      drive_queue(1'b1, 1'b0);
    join
    wait (seen_cnt == n_ph1);
    @(posedge aclk);
    burst <= 1'b1;
    repeat (3) @(posedge aclk);  // Readies settle high, pipeline empty
    fork
      drive_queue(1'b0, 1'b1);
      drive_queue(1'b1, 1'b1);
    join
    wait (seen_cnt == n_vec);
    repeat (20) @(posedge aclk);  // Room for a late duplicate to show

    for (i = 0; i < 4; i++) begin
      check_value({"count ", port_name(i)}, 128'(tot_cnt[i]), 128'(obs_cnt[i]));
    end
    $display("Closing with %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (loaded);
    repeat (50 * n_vec + 100) @(posedge aclk);
    $display("Watchdog expired after %0d cycles, requests still outstanding",
             50 * n_vec + 100);
    $display("test failed");
    $finish;
  end

endmodule

// ==== test/user_req_testdata.txt ====
// group (phase digit, queue digit 0 rd 1 wr) _ vaddr _ len _ vfid _ dest _ flags _ expected (0 local 1 net)
// flags bits are remote, host, actv, last from the top; phase 1 runs with steady ready
00_000010000040_0000100_0_0_1_0
01_000020000080_0000040_5_1_5_0
00_00a1b2000c00_0001000_0_2_9_1
01_0003e8001000_0000800_f_3_d_1
00_7ffff0000000_fffffff_2_0_3_0
00_00a1b3000000_0000010_0_1_8_1
01_123456789abc_0abcdef_1_2_0_0
01_00ff00002000_0000200_0_0_9_1
00_fedcba987654_0000001_9_4_6_0
01_0000beef0000_0000004_0_5_1_0
00_00000a00a000_0004000_6_6_b_1
01_00abcd000400_0000020_0_7_c_1
00_000000001000_0000040_0_8_0_0
01_ffffffffffff_0000002_e_9_f_1
00_000000002000_0000080_0_2_1_0
01_000000003000_0000100_0_3_1_0
10_001111000010_0000400_0_0_9_1
11_002222000020_0000400_0_0_9_1
10_001111000020_0000400_0_1_9_1
11_002222000040_0000400_0_1_9_1
10_001111000030_0000400_0_2_9_1
11_002222000060_0000400_0_2_9_1
10_001111000040_0000400_0_3_b_1
11_002222000080_0000400_0_3_d_1
